/* i2c_regbank_pkg.sv */
`default_nettype none

package i2c_regbank_pkg;

    // data bytes and register addresses share one width
    typedef logic [7:0] reg_byte_t;

    typedef logic [6:0] dev_addr_t;

    // first byte after a start, seen raw or split into address and direction
    typedef union packed {
        reg_byte_t raw;
        struct packed {
            dev_addr_t dev_addr;
            logic      rd;         // 1 = master reads
        } fields;
    } ctrl_byte_u;

    parameter int REG_COUNT    = 8;
    parameter int RW_REG_COUNT = 4;   // regs 0..3 writable, rest read only

    parameter reg_byte_t REG_DEFAULTS [REG_COUNT] = '{
        8'h80,
        8'h95,
        8'h03,
        8'h1D,
        8'h10,
        8'h20,
        8'h30,
        8'h40
    };

    parameter reg_byte_t UNMAPPED_READ_VALUE = 8'hFF;

endpackage

`default_nettype wire

/* i2c_line_if.sv */
`timescale 1ns/1ns
`default_nettype none

// filtered bus lines, one producer and several consumers
interface i2c_line_if;

    logic scl_rise;
    logic scl_fall;
    logic scl_high;    // high for two samples in a row
    logic sda_rise;
    logic sda_fall;
    logic sda_level;

    modport source (
        output scl_rise, scl_fall, scl_high, sda_rise, sda_fall, sda_level
    );

    modport sink (
        input scl_rise, scl_fall, scl_high, sda_rise, sda_fall, sda_level
    );

endinterface

`default_nettype wire

/* i2c_reg_access_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface i2c_reg_access_if;

    logic                       wr_strobe;
    logic                       rd_strobe;
    i2c_regbank_pkg::reg_byte_t addr;
    i2c_regbank_pkg::reg_byte_t wr_data;
    i2c_regbank_pkg::reg_byte_t rd_data;   // valid the cycle after rd_strobe

    modport master (
        output wr_strobe, rd_strobe, addr, wr_data,
        input  rd_data
    );

    modport slave (
        input  wr_strobe, rd_strobe, addr, wr_data,
        output rd_data
    );

endinterface

`default_nettype wire

/* i2c_line_filter.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_line_filter #(
    parameter int FILTER_LEN = 10
) (
    input  logic         CLOCK,
    input  logic         RESET,
    input  logic         scl,
    input  logic         sda_in,
    i2c_line_if.source   line
);

    localparam int SCL_IDX = 0;
    localparam int SDA_IDX = 1;

    logic [1:0]                 raw;
    logic [1:0][FILTER_LEN-1:0] pipe;      // sample history per line
    logic [1:0]                 level;
    logic [1:0]                 level_d;   // previous filtered value

    assign raw = {sda_in, scl};

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            pipe    <= '1;   // idle bus is high
            level   <= 2'b11;
            level_d <= 2'b11;
        end
        else
        begin
            level_d <= level;
            for (int i = 0; i < 2; i++)
            begin
                pipe[i] <= {pipe[i][FILTER_LEN-2:0], raw[i]};
                // only a full run of equal samples moves the level
                if (&pipe[i])
                    level[i] <= 1'b1;
                else if (~|pipe[i])
                    level[i] <= 1'b0;
            end
        end
    end

    assign line.scl_rise  = level[SCL_IDX] & ~level_d[SCL_IDX];
    assign line.scl_fall  = ~level[SCL_IDX] & level_d[SCL_IDX];
    assign line.scl_high  = level[SCL_IDX] & level_d[SCL_IDX];
    assign line.sda_rise  = level[SDA_IDX] & ~level_d[SDA_IDX];
    assign line.sda_fall  = ~level[SDA_IDX] & level_d[SDA_IDX];
    assign line.sda_level = level[SDA_IDX];

    // filtered scl holds for a full run of samples before it may move again
    a_scl_edge_spacing: assert property (
        @(posedge CLOCK) disable iff (RESET)
            (line.scl_rise || line.scl_fall)
                |-> level_d[SCL_IDX] == $past(level[SCL_IDX], FILTER_LEN)
    );

endmodule

`default_nettype wire

/* i2c_bus_condition.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_bus_condition (
    input  logic        CLOCK,
    input  logic        RESET,
    i2c_line_if.sink    line,
    output logic        start,
    output logic        stop
);

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            start <= 1'b0;
            stop  <= 1'b0;
        end
        else
        begin
            // sda may only move while scl is low, except for these two
            start <= line.scl_high & line.sda_fall;
            stop  <= line.scl_high & line.sda_rise;
        end
    end

    a_start_stop_exclusive: assert property (
        @(posedge CLOCK) disable iff (RESET) !(start && stop)
    );

endmodule

`default_nettype wire

/* i2c_byte_receiver.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_byte_receiver (
    input  logic                        CLOCK,
    input  logic                        RESET,
    i2c_line_if.sink                    line,
    input  logic                        rx_go,
    input  logic                        rx_ack_en,
    input  logic                        abort,
    output i2c_regbank_pkg::reg_byte_t  rx_byte,
    output logic                        rx_done,
    output logic                        sda_pull
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_BITS,
        RX_SLOT,   // last bit in and waiting for scl low
        RX_ACK
    } rx_state_t;

    rx_state_t                  state;
    logic [2:0]                 bit_cnt;
    i2c_regbank_pkg::reg_byte_t shift_q;

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            state    <= RX_IDLE;
            bit_cnt  <= '0;
            rx_done  <= 1'b0;
            sda_pull <= 1'b0;
        end
        else
        begin
            rx_done <= 1'b0;
            if (abort)
            begin
                state    <= RX_IDLE;
                sda_pull <= 1'b0;
            end
            else
            begin
                case (state)
                    RX_IDLE:
                        if (rx_go)
                        begin
                            bit_cnt <= '0;
                            state   <= RX_BITS;
                        end
                    RX_BITS:
                        if (line.scl_rise)
                        begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                                state <= RX_SLOT;
                        end
                    RX_SLOT:
                        if (line.scl_fall)
                        begin
                            if (rx_ack_en)
                            begin
                                sda_pull <= 1'b1;   // ack held for one scl period
                                state    <= RX_ACK;
                            end
                            else
                            begin
                                rx_done <= 1'b1;
                                state   <= RX_IDLE;
                            end
                        end
                    RX_ACK:
                        if (line.scl_fall)
                        begin
                            sda_pull <= 1'b0;
                            rx_done  <= 1'b1;
                            state    <= RX_IDLE;
                        end
                    default:
                        state <= RX_IDLE;
                endcase
            end
        end
    end

    // sampled msb first while scl goes high
    always_ff @(posedge CLOCK)
    begin
        if (state == RX_BITS && line.scl_rise)
            shift_q <= {shift_q[6:0], line.sda_level};
    end

    assign rx_byte = shift_q;

    // the ack pull moves only while scl is low or on a bus condition
    a_pull_while_scl_low: assert property (
        @(posedge CLOCK) disable iff (RESET)
            $changed(sda_pull) |-> !line.scl_high || $past(abort)
    );

endmodule

`default_nettype wire

/* i2c_byte_transmitter.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_byte_transmitter (
    input  logic                        CLOCK,
    input  logic                        RESET,
    i2c_line_if.sink                    line,
    input  logic                        tx_load,
    input  i2c_regbank_pkg::reg_byte_t  tx_byte,
    input  logic                        abort,
    output logic                        tx_done,
    output logic                        sda_pull
);

    logic                       busy;
    logic [2:0]                 bit_cnt;
    i2c_regbank_pkg::reg_byte_t shift_q;   // bit 7 is on the bus

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            tx_done <= 1'b0;
        end
        else
        begin
            tx_done <= 1'b0;
            if (abort)
                busy <= 1'b0;
            else if (tx_load)
            begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end
            else if (busy && line.scl_fall)
            begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7)
                begin
                    busy    <= 1'b0;   // master owns sda for its ack
                    tx_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK)
    begin
        if (tx_load)
            shift_q <= tx_byte;
        else if (busy && line.scl_fall)
            shift_q <= {shift_q[6:0], 1'b0};
    end

    // open drain, ones are left to the pull-up
    assign sda_pull = busy & ~shift_q[7];

endmodule

`default_nettype wire

/* i2c_transaction_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_transaction_ctrl #(
    parameter i2c_regbank_pkg::dev_addr_t SLAVE_ADDR = 7'h50
) (
    input  logic                        CLOCK,
    input  logic                        RESET,
    input  logic                        start,
    input  logic                        stop,
    output logic                        rx_go,
    output logic                        rx_ack_en,
    input  i2c_regbank_pkg::reg_byte_t  rx_byte,
    input  logic                        rx_done,
    output logic                        tx_load,
    output i2c_regbank_pkg::reg_byte_t  tx_byte,
    input  logic                        tx_done,
    output logic                        abort,
    i2c_reg_access_if.master            regs,
    output logic                        wr_en,
    output i2c_regbank_pkg::reg_byte_t  reg_addr,
    output i2c_regbank_pkg::reg_byte_t  wr_data
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CTRL,
        ST_REG_ADDR,
        ST_DATA,
        ST_READ,
        ST_WAIT_STOP
    } state_t;

    state_t                      state;
    i2c_regbank_pkg::ctrl_byte_u ctrl;
    logic                        addr_match;
    i2c_regbank_pkg::reg_byte_t  addr_q;
    i2c_regbank_pkg::reg_byte_t  data_q;

    assign ctrl.raw   = rx_byte;
    assign addr_match = (ctrl.fields.dev_addr == SLAVE_ADDR);
    assign abort      = start | stop;   // any bus condition resets the shifters

    assign tx_byte      = regs.rd_data;
    assign regs.addr    = addr_q;
    assign regs.wr_data = data_q;

    always_comb
    begin
        case (state)
            ST_CTRL:              rx_ack_en = addr_match;
            ST_REG_ADDR, ST_DATA: rx_ack_en = 1'b1;
            default:              rx_ack_en = 1'b0;
        endcase
    end

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            state          <= ST_IDLE;
            rx_go          <= 1'b0;
            tx_load        <= 1'b0;
            regs.wr_strobe <= 1'b0;
            regs.rd_strobe <= 1'b0;
            addr_q         <= '0;
            data_q         <= '0;
        end
        else
        begin
            rx_go          <= 1'b0;
            regs.wr_strobe <= 1'b0;
            regs.rd_strobe <= 1'b0;
            tx_load        <= regs.rd_strobe;   // rd_data is ready by now
            if (stop)
                state <= ST_IDLE;
            else if (start)
            begin
                state <= ST_CTRL;   // also covers repeated start
                rx_go <= 1'b1;
            end
            else
            begin
                case (state)
                    ST_CTRL:
                        if (rx_done)
                        begin
                            if (!addr_match)
                                state <= ST_WAIT_STOP;
                            else if (ctrl.fields.rd)
                            begin
                                state          <= ST_READ;
                                regs.rd_strobe <= 1'b1;
                            end
                            else
                            begin
                                state <= ST_REG_ADDR;
                                rx_go <= 1'b1;
                            end
                        end
                    ST_REG_ADDR:
                        if (rx_done)
                        begin
                            addr_q <= rx_byte;
                            rx_go  <= 1'b1;
                            state  <= ST_DATA;
                        end
                    ST_DATA:
                        if (rx_done)
                        begin
                            data_q         <= rx_byte;
                            regs.wr_strobe <= 1'b1;
                            state          <= ST_WAIT_STOP;   // single byte only
                        end
                    ST_READ:
                        if (tx_done)
                            state <= ST_WAIT_STOP;   // master ack not checked
                    default:
                        state <= state;
                endcase
            end
        end
    end

    // write notification held until the next write
    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            wr_en    <= 1'b0;
            reg_addr <= '0;
            wr_data  <= '0;
        end
        else
        begin
            wr_en <= regs.wr_strobe;
            if (regs.wr_strobe)
            begin
                reg_addr <= addr_q;
                wr_data  <= data_q;
            end
        end
    end

    // a write notice only ever closes a received data byte
    a_wr_en_after_strobe: assert property (
        @(posedge CLOCK) disable iff (RESET)
            wr_en |-> $past(regs.wr_strobe) && $past(state == ST_DATA && rx_done, 2)
    );

endmodule

`default_nettype wire

/* i2c_register_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_register_bank (
    input  logic            CLOCK,
    input  logic            RESET,
    i2c_reg_access_if.slave regs
);

    localparam int IDX_W = $clog2(i2c_regbank_pkg::REG_COUNT);

    i2c_regbank_pkg::reg_byte_t bank [i2c_regbank_pkg::REG_COUNT];
    logic                       wr_ok;
    logic                       rd_mapped;

    // upper registers keep their defaults
    assign wr_ok     = regs.addr < i2c_regbank_pkg::RW_REG_COUNT;
    assign rd_mapped = regs.addr < i2c_regbank_pkg::REG_COUNT;

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < i2c_regbank_pkg::REG_COUNT; i++)
                bank[i] <= i2c_regbank_pkg::REG_DEFAULTS[i];
        end
        else if (regs.wr_strobe && wr_ok)
            bank[regs.addr[IDX_W-1:0]] <= regs.wr_data;
    end

    always_ff @(posedge CLOCK)
    begin
        if (regs.rd_strobe)
        begin
            if (rd_mapped)
                regs.rd_data <= bank[regs.addr[IDX_W-1:0]];
            else
                regs.rd_data <= i2c_regbank_pkg::UNMAPPED_READ_VALUE;
        end
    end

endmodule

`default_nettype wire

/* i2c_regbank_top.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_regbank_top #(
    parameter i2c_regbank_pkg::dev_addr_t SLAVE_ADDR = 7'h50,
    parameter int                         FILTER_LEN = 10
) (
    input  logic                        CLOCK,
    input  logic                        RESET,
    input  logic                        scl,
    inout  wire                         sda,       // needs an external pull-up
    output logic                        wr_en,
    output i2c_regbank_pkg::reg_byte_t  reg_addr,
    output i2c_regbank_pkg::reg_byte_t  wr_data
);

    i2c_line_if       line_bus ();
    i2c_reg_access_if reg_bus ();

    logic                       start;
    logic                       stop;
    logic                       abort;
    logic                       rx_go;
    logic                       rx_ack_en;
    logic                       rx_done;
    logic                       rx_pull;
    i2c_regbank_pkg::reg_byte_t rx_byte;
    logic                       tx_load;
    logic                       tx_done;
    logic                       tx_pull;
    i2c_regbank_pkg::reg_byte_t tx_byte;

    // open drain, either shifter may pull low
    assign sda = (rx_pull | tx_pull) ? 1'b0 : 1'bz;

    i2c_line_filter #(
        .FILTER_LEN (FILTER_LEN)
    ) u_line_filter (
        .CLOCK  (CLOCK),
        .RESET  (RESET),
        .scl    (scl),
        .sda_in (sda),
        .line   (line_bus.source)
    );

    i2c_bus_condition u_bus_condition (
        .CLOCK (CLOCK),
        .RESET (RESET),
        .line  (line_bus.sink),
        .start (start),
        .stop  (stop)
    );

    i2c_byte_receiver u_byte_receiver (
        .CLOCK     (CLOCK),
        .RESET     (RESET),
        .line      (line_bus.sink),
        .rx_go     (rx_go),
        .rx_ack_en (rx_ack_en),
        .abort     (abort),
        .rx_byte   (rx_byte),
        .rx_done   (rx_done),
        .sda_pull  (rx_pull)
    );

    i2c_byte_transmitter u_byte_transmitter (
        .CLOCK    (CLOCK),
        .RESET    (RESET),
        .line     (line_bus.sink),
        .tx_load  (tx_load),
        .tx_byte  (tx_byte),
        .abort    (abort),
        .tx_done  (tx_done),
        .sda_pull (tx_pull)
    );

    i2c_transaction_ctrl #(
        .SLAVE_ADDR (SLAVE_ADDR)
    ) u_transaction_ctrl (
        .CLOCK     (CLOCK),
        .RESET     (RESET),
        .start     (start),
        .stop      (stop),
        .rx_go     (rx_go),
        .rx_ack_en (rx_ack_en),
        .rx_byte   (rx_byte),
        .rx_done   (rx_done),
        .tx_load   (tx_load),
        .tx_byte   (tx_byte),
        .tx_done   (tx_done),
        .abort     (abort),
        .regs      (reg_bus.master),
        .wr_en     (wr_en),
        .reg_addr  (reg_addr),
        .wr_data   (wr_data)
    );

    i2c_register_bank u_register_bank (
        .CLOCK (CLOCK),
        .RESET (RESET),
        .regs  (reg_bus.slave)
    );

endmodule

`default_nettype wire

/* tb_i2c_master.svh */
`ifndef TB_I2C_MASTER_SVH
`define TB_I2C_MASTER_SVH

// bit-banged master, every change lands on a rising clock edge
localparam int SCL_HALF    = 30;   // clocks per scl half period
localparam int SCL_QUARTER = 15;

task automatic idle_clocks(input int n);
    repeat (n) @(posedge CLOCK);
endtask

// scl and sda are both released on entry
task automatic start_condition();
    idle_clocks(SCL_QUARTER);
    sda_low <= 1'b1;   // sda falls while scl is high
    idle_clocks(SCL_HALF);
    scl_drv <= 1'b0;
endtask

// scl is low on entry, high sda then falls inside scl high
task automatic repeated_start();
    idle_clocks(SCL_QUARTER);
    sda_low <= 1'b0;
    idle_clocks(SCL_HALF - SCL_QUARTER);
    scl_drv <= 1'b1;
    idle_clocks(SCL_QUARTER);
    sda_low <= 1'b1;
    idle_clocks(SCL_HALF - SCL_QUARTER);
    scl_drv <= 1'b0;
endtask

task automatic stop_condition();
    idle_clocks(SCL_QUARTER);
    sda_low <= 1'b1;
    idle_clocks(SCL_HALF - SCL_QUARTER);
    scl_drv <= 1'b1;
    idle_clocks(SCL_QUARTER);
    sda_low <= 1'b0;   // sda rises while scl is high
    idle_clocks(SCL_HALF);
endtask

// sda changes a quarter period after scl falls, clear of the slave's own changes
task automatic write_bit(input logic b);
    idle_clocks(SCL_QUARTER);
    sda_low <= ~b;
    idle_clocks(SCL_HALF - SCL_QUARTER);
    scl_drv <= 1'b1;
    idle_clocks(SCL_HALF);
    scl_drv <= 1'b0;
endtask

task automatic read_bit(output logic b);
    idle_clocks(SCL_QUARTER);
    sda_low <= 1'b0;
    idle_clocks(SCL_HALF - SCL_QUARTER);
    scl_drv <= 1'b1;
    idle_clocks(SCL_QUARTER);
    b = sda;   // middle of scl high
    idle_clocks(SCL_HALF - SCL_QUARTER);
    scl_drv <= 1'b0;
endtask

task automatic write_byte(input i2c_regbank_pkg::reg_byte_t data, output logic ack);
    for (int i = 7; i >= 0; i--)
        write_bit(data[i]);
    read_bit(ack);   // 0 means the slave acknowledged
endtask

task automatic read_byte(output i2c_regbank_pkg::reg_byte_t data, input logic ack);
    logic b;
    for (int i = 7; i >= 0; i--)
    begin
        read_bit(b);
        data[i] = b;
    end
    write_bit(ack);
endtask

// short low pulse on an idle bus
task automatic scl_glitch(input int width);
    idle_clocks(1);
    scl_drv <= 1'b0;
    idle_clocks(width);
    scl_drv <= 1'b1;
    idle_clocks(SCL_HALF);
endtask

`endif

/* tb_i2c_regbank.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_i2c_regbank;

    localparam i2c_regbank_pkg::dev_addr_t DUT_ADDR = 7'h50;
    localparam int FILTER_LEN         = 10;
    localparam int CYCLES_PER_PATTERN = 4000;

    logic                       CLOCK;
    logic                       RESET;
    logic                       scl_drv;
    logic                       sda_low;   // master pulls sda
    wire                        sda;
    logic                       wr_en;
    i2c_regbank_pkg::reg_byte_t reg_addr;
    i2c_regbank_pkg::reg_byte_t wr_data;

    logic [7:0]                 pat_op   [$];
    i2c_regbank_pkg::dev_addr_t pat_dev  [$];
    i2c_regbank_pkg::reg_byte_t pat_addr [$];
    i2c_regbank_pkg::reg_byte_t pat_data [$];
    logic                       pat_ack  [$];
    int                         num_patterns   = 0;
    logic                       patterns_ready = 1'b0;
    int                         wr_cycles      = 0;

    // expected register contents and the last write seen on the outputs
    i2c_regbank_pkg::reg_byte_t model [i2c_regbank_pkg::REG_COUNT];
    i2c_regbank_pkg::reg_byte_t last_addr;
    i2c_regbank_pkg::reg_byte_t last_data;

    pullup (sda);
    assign sda = sda_low ? 1'b0 : 1'bz;

    i2c_regbank_top #(
        .SLAVE_ADDR (DUT_ADDR),
        .FILTER_LEN (FILTER_LEN)
    ) UUT (
        .CLOCK    (CLOCK),
        .RESET    (RESET),
        .scl      (scl_drv),
        .sda      (sda),
        .wr_en    (wr_en),
        .reg_addr (reg_addr),
        .wr_data  (wr_data)
    );

    `include "tb_i2c_master.svh"

    initial
    begin
        CLOCK = 1'b0;
        forever #20 CLOCK = ~CLOCK;
    end

    always @(negedge CLOCK)
    begin
        if (!RESET && wr_en === 1'b1)
            wr_cycles = wr_cycles + 1;
    end

    task automatic stop_on_error();
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_byte(input string name, input i2c_regbank_pkg::reg_byte_t actual,
                              input i2c_regbank_pkg::reg_byte_t expected);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
            stop_on_error();
        end
    endtask

    task automatic check_ack(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("[FAIL] sda at %s: got %h, expected %h", name, actual, expected);
            stop_on_error();
        end
    endtask

    task automatic check_strobe(input int exp_cycles, input i2c_regbank_pkg::reg_byte_t exp_addr,
                                input i2c_regbank_pkg::reg_byte_t exp_data);
        if (wr_cycles != exp_cycles)
        begin
            $display("[FAIL] wr_en cycles high: got %h, expected %h", wr_cycles, exp_cycles);
            stop_on_error();
        end
        check_byte("reg_addr", reg_addr, exp_addr);
        check_byte("wr_data", wr_data, exp_data);
    endtask

    function automatic i2c_regbank_pkg::reg_byte_t predict_read(
        input i2c_regbank_pkg::reg_byte_t addr);
        if (addr < i2c_regbank_pkg::REG_COUNT)
            return model[addr[2:0]];
        return i2c_regbank_pkg::UNMAPPED_READ_VALUE;
    endfunction

    task automatic load_patterns();
        int          fd;
        int          n;
        logic [8*128-1:0] text;
        logic [7:0]  op;
        logic [31:0] dev;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] ack;
        fd = $fopen("i2c_regbank_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the pattern file i2c_regbank_patterns.txt");
            stop_on_error();
        end
        while (!$feof(fd))
        begin
            text = '0;
            n = $fgets(text, fd);
            n = $sscanf(text, "%s %h %h %h %h", op, dev, addr, data, ack);
            if (n == 5 && op != "#")   // comment and blank lines are skipped
            begin
                pat_op.push_back(op);
                pat_dev.push_back(dev[6:0]);
                pat_addr.push_back(addr[7:0]);
                pat_data.push_back(data[7:0]);
                pat_ack.push_back(ack[0]);
            end
        end
        $fclose(fd);
        num_patterns = pat_op.size();
    endtask

    task automatic run_write(input int i);
        i2c_regbank_pkg::ctrl_byte_u ctrl;
        logic                        ack;
        if (pat_ack[i] !== (pat_dev[i] != DUT_ADDR))
        begin
            $display("pattern %0d expects an ack that the device address rules out", i);
            stop_on_error();
        end
        ctrl.fields.dev_addr = pat_dev[i];
        ctrl.fields.rd       = 1'b0;
        wr_cycles = 0;
        start_condition();
        write_byte(ctrl.raw, ack);
        check_ack("control byte ack", ack, pat_ack[i]);
        // the whole frame is sent, so a device that was not addressed must ignore it
        write_byte(pat_addr[i], ack);
        check_ack("register address ack", ack, pat_ack[i]);
        write_byte(pat_data[i], ack);
        check_ack("data byte ack", ack, pat_ack[i]);
        if (!pat_ack[i])
        begin
            last_addr = pat_addr[i];
            last_data = pat_data[i];
            if (pat_addr[i] < i2c_regbank_pkg::RW_REG_COUNT)
                model[pat_addr[i][2:0]] = pat_data[i];   // upper regs ignore writes
        end
        stop_condition();
        check_strobe(pat_ack[i] ? 0 : 1, last_addr, last_data);
    endtask

    task automatic run_read(input int i);
        i2c_regbank_pkg::ctrl_byte_u ctrl;
        i2c_regbank_pkg::reg_byte_t  value;
        logic                        ack;
        if (pat_data[i] !== predict_read(pat_addr[i]) || pat_ack[i] !== (pat_dev[i] != DUT_ADDR))
        begin
            $display("pattern %0d disagrees with the register rules", i);
            stop_on_error();
        end
        ctrl.fields.dev_addr = pat_dev[i];
        ctrl.fields.rd       = 1'b0;
        wr_cycles = 0;
        start_condition();
        write_byte(ctrl.raw, ack);
        check_ack("control byte ack", ack, pat_ack[i]);
        if (!pat_ack[i])
        begin
            write_byte(pat_addr[i], ack);
            check_ack("register address ack", ack, 1'b0);
            repeated_start();
            ctrl.fields.rd = 1'b1;
            write_byte(ctrl.raw, ack);
            check_ack("read control byte ack", ack, 1'b0);
            read_byte(value, 1'b1);   // nack ends the read
            check_byte("read data", value, pat_data[i]);
        end
        stop_condition();
        check_strobe(0, last_addr, last_data);   // a read never writes
    endtask

    initial
    begin
        wait (patterns_ready);
        repeat (num_patterns * CYCLES_PER_PATTERN) @(posedge CLOCK);
        $display("watchdog expired before all %0d patterns were done", num_patterns);
        stop_on_error();
    end

    initial
    begin
        RESET   = 1'b1;
        scl_drv = 1'b1;
        sda_low = 1'b0;
        last_addr = '0;
        last_data = '0;
        for (int r = 0; r < i2c_regbank_pkg::REG_COUNT; r++)
            model[r] = i2c_regbank_pkg::REG_DEFAULTS[r];
        load_patterns();
        if (num_patterns == 0)
        begin
            $display("the pattern file holds no patterns");
            stop_on_error();
        end
        patterns_ready = 1'b1;
        repeat (8) @(posedge CLOCK);
        RESET <= 1'b0;
        idle_clocks(SCL_HALF);
        check_strobe(0, 8'h00, 8'h00);   // outputs cleared by reset
        for (int i = 0; i < num_patterns; i++)
        begin
            case (pat_op[i])
                "W": run_write(i);
                "R": run_read(i);
                "G":
                begin
                    wr_cycles = 0;
                    scl_glitch(3);
                    check_strobe(0, last_addr, last_data);
                end
                default:
                begin
                    $display("pattern %0d has an unknown operation", i);
                    stop_on_error();
                end
            endcase
            idle_clocks(SCL_HALF);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* i2c_regbank_patterns.txt */
# op dev reg data ack  (W write, R read with expected data, G scl glitch while idle)
# ack is the control byte acknowledge seen on sda, 0 = acknowledged
R 50 00 80 0
R 50 01 95 0
R 50 02 03 0
R 50 03 1D 0
R 50 04 10 0
R 50 05 20 0
R 50 06 30 0
R 50 07 40 0
W 50 00 5A 0
W 50 01 A5 0
W 50 02 3C 0
W 50 03 C3 0
R 50 00 5A 0
R 50 03 C3 0
W 50 05 77 0
R 50 05 20 0
R 50 08 FF 0
R 50 2A FF 0
W 51 02 EE 1
R 50 02 3C 0
G 00 00 00 0
R 50 01 A5 0

/* i2c_regbank.f */
+incdir+.
i2c_regbank_pkg.sv
i2c_line_if.sv
i2c_reg_access_if.sv
i2c_line_filter.sv
i2c_bus_condition.sv
i2c_byte_receiver.sv
i2c_byte_transmitter.sv
i2c_transaction_ctrl.sv
i2c_register_bank.sv
i2c_regbank_top.sv
tb_i2c_regbank.sv
